//--- flist.f
+incdir+hdl
hdl/memSysPkg.sv
hdl/instrCache.sv
hdl/dataCache.sv
hdl/busArbiter.sv
hdl/busMemory.sv
hdl/memSubsystem.sv
dv/memSubsystemTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --top-module memSubsystemTb -f flist.f -o memSubsystemSim
./obj_dir/memSubsystemSim | tee sim.log
if grep -q "^PASS: all tests$" sim.log
then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- dv/memSubsystemTb.sv
// Memory subsystem testbench with core-side drivers, shadow memory reference, compare tasks and tests
`timescale 1ns/1ns
`include "memSys_defines.svh"
`default_nettype none

module memSubsystemTb;
  import memSysPkg::*;

  localparam int   timeoutCycles = 200;
  localparam int   memIdxW       = $clog2(`MEM_WORDS);
  localparam addrT noRequest     = 32'hffff_ffff;

  logic    clk;
  logic    arstN;
  logic    iCacheEn;
  logic    dCacheEn;
  logic    invI;
  logic    invD;
  logic    fetchValid;
  addrT    fetchAddr;
  logic    fetchReady;
  logic    instrValid;
  wordT    instr;
  logic    dataValid;
  dataReqT dataReq;
  logic    dataReady;
  logic    rdValid;
  wordT    rdData;

  // Expected memory contents, updated when a write is accepted
  wordT  shadow [`MEM_WORDS];
  addrT  fetchQ [$];
  addrT  readQ [$];
  string testName;
  int    errCount;
  int    checkCount;
  logic  stuck = 1'b0;

  memSubsystem i_dut (
    .clk       (clk       ),
    .arstN     (arstN     ),
    .iCacheEn  (iCacheEn  ),
    .dCacheEn  (dCacheEn  ),
    .invI      (invI      ),
    .invD      (invD      ),
    .fetchValid(fetchValid),
    .fetchAddr (fetchAddr ),
    .fetchReady(fetchReady),
    .instrValid(instrValid),
    .instr     (instr     ),
    .dataValid (dataValid ),
    .dataReq   (dataReq   ),
    .dataReady (dataReady ),
    .rdValid   (rdValid   ),
    .rdData    (rdData    )
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic wordT refRead(input addrT addr);
    return shadow[addr[2 +: memIdxW]];
  endfunction

  // Enabled byte lanes take the new data
  function automatic void mergeShadow(input addrT addr, input wordT wdata, input byteMaskT mask);
    wordT w;
    w = shadow[addr[2 +: memIdxW]];
    for (int b = 0; b < 4; b++)
    begin
      if (mask[b])
        w[8*b +: 8] = wdata[8*b +: 8];
    end
    shadow[addr[2 +: memIdxW]] = w;
  endfunction

  function automatic byteMaskT randMask();
    return byteMaskT'($urandom_range(15, 1));
  endfunction

  // Window of three tags over the same eight indices, so lines collide
  function automatic addrT winAddrAt(input int t, input int i, input int w);
    return addrT'(32'h0000_2800 + 1024*t + 16*i + 4*w);
  endfunction

  function automatic addrT winAddr(input int t);
    return winAddrAt(t, int'($urandom_range(7, 0)), int'($urandom_range(3, 0)));
  endfunction

  task automatic checkWord(input string name, input wordT expected, input wordT actual);
    checkCount++;
    if (actual !== expected)
    begin
      errCount++;
      $display("** Error [%s] expected %h, actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic checkAddr(input string name, input addrT expected, input addrT actual);
    checkCount++;
    if (actual !== expected)
    begin
      errCount++;
      $display("** Error [%s] expected address %h, actual address %h at %0t",
               name, expected, actual, $time);
    end
  endtask

  task automatic reportFault(input string what);
    errCount++;
    $display("Error [%s]: %s at %0t", testName, what, $time);
  endtask

  task automatic giveUp(input string what);
    errCount++;
    $display("Error [%s]: no %s within %0d cycles", testName, what, timeoutCycles);
    stuck = 1'b1;
  endtask

  // Ends the run as soon as any wait has timed out
  initial
  begin : watchdog
    wait (stuck);
    $display("Checks: %0d, errors: %0d", checkCount, errCount);
    $display("FAIL: see errors above");
    $finish;
  end

  // Pairs each response with the oldest accepted request of its port
  initial
  begin : monitor
    addrT a;
    forever
    begin
      @(negedge clk);
      #1;
      if (instrValid)
      begin
        if (fetchQ.size() == 0)
          checkAddr({testName, ": instr with no fetch"}, noRequest, fetchAddr);
        else
        begin
          a = fetchQ.pop_front();
          checkWord(testName, refRead(a), instr);
        end
      end
      if (rdValid)
      begin
        if (readQ.size() == 0)
          checkAddr({testName, ": read data with no read"}, noRequest, dataReq.addr);
        else
        begin
          a = readQ.pop_front();
          checkWord(testName, refRead(a), rdData);
        end
      end
      if (fetchValid && fetchReady)
        fetchQ.push_back(fetchAddr);
      if (dataValid && dataReady && !dataReq.write)
        readQ.push_back(dataReq.addr);
    end
  end

  // Returns on the falling edge after the fetch was taken, fetchValid still high
  task automatic fetchIssue(input addrT addr, output int waited);
    int n;
    n          = 0;
    fetchValid = 1'b1;
    fetchAddr  = addr;
    while (!fetchReady && (n < timeoutCycles))
    begin
      @(negedge clk);
      n++;
    end
    if (!fetchReady)
      giveUp("fetchReady");
    waited = n;
    @(negedge clk);
  endtask

  task automatic waitFetchDone();
    int n;
    n = 0;
    while ((fetchQ.size() != 0) && (n < timeoutCycles))
    begin
      @(negedge clk);
      n++;
    end
    if (fetchQ.size() != 0)
      giveUp("instrValid");
  endtask

  task automatic waitFetchIdle();
    int n;
    n = 0;
    while (!fetchReady && (n < timeoutCycles))
    begin
      @(negedge clk);
      n++;
    end
    if (!fetchReady)
      giveUp("idle instruction cache");
  endtask

  task automatic fetchOne(input addrT addr);
    int waited;
    fetchIssue(addr, waited);
    fetchValid = 1'b0;
    waitFetchDone();
  endtask

  task automatic dataIssue(input dataReqT req);
    int n;
    n         = 0;
    dataValid = 1'b1;
    dataReq   = req;
    while (!dataReady && (n < timeoutCycles))
    begin
      @(negedge clk);
      n++;
    end
    if (!dataReady)
      giveUp("dataReady");
    if (req.write)
      mergeShadow(req.addr, req.wdata, req.byteMask);
    @(negedge clk);
    dataValid = 1'b0;
  endtask

  task automatic dataWrite(input addrT addr, input wordT wdata, input byteMaskT mask);
    dataReqT req;
    int      n;
    req.addr     = addr;
    req.write    = 1'b1;
    req.wdata    = wdata;
    req.byteMask = mask;
    dataIssue(req);
    n = 0;
    // dataReady comes back once memory has taken the write
    while (!dataReady && (n < timeoutCycles))
    begin
      @(negedge clk);
      n++;
    end
    if (!dataReady)
      giveUp("write completion");
  endtask

  task automatic dataRead(input addrT addr);
    dataReqT req;
    int      n;
    req.addr     = addr;
    req.write    = 1'b0;
    req.wdata    = '0;
    req.byteMask = '0;
    dataIssue(req);
    n = 0;
    while ((readQ.size() != 0) && (n < timeoutCycles))
    begin
      @(negedge clk);
      n++;
    end
    if (readQ.size() != 0)
      giveUp("rdValid");
  endtask

  task automatic pulseInv(input logic instrSide);
    if (instrSide)
      invI = 1'b1;
    else
      invD = 1'b1;
    @(negedge clk);
    invI = 1'b0;
    invD = 1'b0;
    @(negedge clk);
  endtask

  initial
  begin : main
    int waited;
    arstN      = 1'b0;
    iCacheEn   = 1'b0;
    dCacheEn   = 1'b0;
    invI       = 1'b0;
    invD       = 1'b0;
    fetchValid = 1'b0;
    fetchAddr  = '0;
    dataValid  = 1'b0;
    dataReq    = '0;
    errCount   = 0;
    checkCount = 0;
    testName   = "reset";
    void'($urandom(32'h2bb6bbc7));
    repeat (3) @(negedge clk);
    arstN    = 1'b1;
    iCacheEn = 1'b1;
    dCacheEn = 1'b1;
    @(negedge clk);

    // Full then partial writes miss without allocating, reads fill and then hit
    testName = "data write read";
    for (int k = 0; k < 16; k++)
      dataWrite(addrT'(32'h0000_0200 + 4*k), $urandom(), 4'hf);
    for (int k = 0; k < 16; k++)
      dataWrite(addrT'(32'h0000_0200 + 4*k), $urandom(), randMask());
    for (int pass = 0; pass < 2; pass++)
    begin
      for (int k = 0; k < 16; k++)
        dataRead(addrT'(32'h0000_0200 + 4*k));
    end

    // Start each line at word 2 so the critical word is not the first of the line
    testName = "fetch after invI";
    pulseInv(1'b1);
    for (int ln = 0; ln < 4; ln++)
    begin
      for (int k = 0; k < 4; k++)
        fetchOne(addrT'(32'h0000_0200 + 16*ln + 4*((k + 2) % 4)));
    end

    testName = "fetch hit latency";
    for (int k = 0; k < 4; k++)
      dataWrite(addrT'(32'h0000_0300 + 4*k), $urandom(), 4'hf);
    fetchOne(addrT'(32'h0000_030c));
    waitFetchIdle();
    if (instrValid)
      reportFault("instrValid still busy before the hit stream");
    for (int k = 0; k < 4; k++)
    begin
      fetchIssue(addrT'(32'h0000_0300 + 4*k), waited);
      if (waited != 0)
        reportFault("fetchReady dropped during back-to-back hits");
      if (!instrValid)
        reportFault("instrValid did not follow an accepted hit by one cycle");
    end
    fetchValid = 1'b0;
    waitFetchDone();

    testName = "write hit merge";
    dataWrite(32'h0000_0204, $urandom(), 4'b0110);
    dataRead(32'h0000_0204);
    dataWrite(32'h0000_0218, $urandom(), 4'b1001);
    dataRead(32'h0000_0218);
    pulseInv(1'b0);
    dataRead(32'h0000_0204);
    dataRead(32'h0000_0218);

    // Data writes stay in one region, fetches read another
    testName = "caches disabled";
    iCacheEn = 1'b0;
    dCacheEn = 1'b0;
    for (int k = 0; k < 64; k++)
    begin
      dataWrite(addrT'(32'h0000_1000 + 4*k), $urandom(), 4'hf);
      dataWrite(addrT'(32'h0000_2000 + 4*k), $urandom(), 4'hf);
    end
    fork
      begin
        for (int k = 0; k < 100; k++)
        begin
          if ($urandom_range(1, 0) == 0)
            dataWrite(addrT'(32'h0000_1000 + 4*$urandom_range(63, 0)), $urandom(), randMask());
          else if ($urandom_range(1, 0) == 0)
            dataRead(addrT'(32'h0000_1000 + 4*$urandom_range(63, 0)));
          else
            dataRead(addrT'(32'h0000_2000 + 4*$urandom_range(63, 0)));
        end
      end
      begin
        for (int k = 0; k < 100; k++)
          fetchOne(addrT'(32'h0000_2000 + 4*$urandom_range(63, 0)));
      end
    join

    // Tags 0 and 1 are fetchable, tag 2 takes data writes while fetches run
    testName = "mixed random";
    iCacheEn = 1'b1;
    dCacheEn = 1'b1;
    pulseInv(1'b1);
    pulseInv(1'b0);
    for (int t = 0; t < 3; t++)
    begin
      for (int i = 0; i < 8; i++)
      begin
        for (int w = 0; w < 4; w++)
          dataWrite(winAddrAt(t, i, w), $urandom(), 4'hf);
      end
    end
    for (int r = 0; r < 20; r++)
    begin
      fork
        begin
          for (int k = 0; k < 10; k++)
          begin
            if ($urandom_range(2, 0) == 0)
              dataWrite(winAddr(2), $urandom(), randMask());
            else
              dataRead(winAddr(int'($urandom_range(2, 0))));
          end
        end
        begin
          for (int k = 0; k < 6; k++)
            fetchOne(winAddr(int'($urandom_range(1, 0))));
        end
      join
      for (int k = 0; k < 4; k++)
        dataWrite(winAddr(int'($urandom_range(1, 0))), $urandom(), randMask());
      // The instruction cache does not snoop, so stale lines go
      pulseInv(1'b1);
    end

    $display("Checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/memSubsystem.sv
// Memory subsystem top with instruction cache, data cache, bus arbiter and bus memory
`timescale 1ns/1ns
`include "memSys_defines.svh"
`default_nettype none

module memSubsystem (
  input  logic               clk,
  input  logic               arstN,
  input  logic               iCacheEn,
  input  logic               dCacheEn,
  input  logic               invI,
  input  logic               invD,
  input  logic               fetchValid,
  input  memSysPkg::addrT    fetchAddr,
  output logic               fetchReady,
  output logic               instrValid,
  output memSysPkg::wordT    instr,
  input  logic               dataValid,
  input  memSysPkg::dataReqT dataReq,
  output logic               dataReady,
  output logic               rdValid,
  output memSysPkg::wordT    rdData
);
  import memSysPkg::*;

  logic   iBusValid;
  logic   iBusReady;
  busReqT iBusReq;
  logic   dBusValid;
  logic   dBusReady;
  busReqT dBusReq;
  logic   memValid;
  logic   memReady;
  busReqT memReq;
  wordT   memRdata;

  instrCache #(
    .lineWords(`LINE_WORDS),
    .lines    (`I_LINES   )
  ) i_instrCache (
    .clk       (clk       ),
    .arstN     (arstN     ),
    .enable    (iCacheEn  ),
    .invalidate(invI      ),
    .fetchValid(fetchValid),
    .fetchAddr (fetchAddr ),
    .fetchReady(fetchReady),
    .instrValid(instrValid),
    .instr     (instr     ),
    .busValid  (iBusValid ),
    .busReq    (iBusReq   ),
    .busReady  (iBusReady ),
    .busRdata  (memRdata  )
  );

  dataCache #(
    .lineWords(`LINE_WORDS),
    .lines    (`D_LINES   )
  ) i_dataCache (
    .clk       (clk      ),
    .arstN     (arstN    ),
    .enable    (dCacheEn ),
    .invalidate(invD     ),
    .dataValid (dataValid),
    .dataReq   (dataReq  ),
    .dataReady (dataReady),
    .rdValid   (rdValid  ),
    .rdData    (rdData   ),
    .busValid  (dBusValid),
    .busReq    (dBusReq  ),
    .busReady  (dBusReady),
    .busRdata  (memRdata )
  );

  // Read data bypasses the arbiter, only the granted side sees ready
  busArbiter i_busArbiter (
    .clk     (clk      ),
    .arstN   (arstN    ),
    .iValid  (iBusValid),
    .iReq    (iBusReq  ),
    .iReady  (iBusReady),
    .dValid  (dBusValid),
    .dReq    (dBusReq  ),
    .dReady  (dBusReady),
    .memValid(memValid ),
    .memReq  (memReq   ),
    .memReady(memReady )
  );

  busMemory #(
    .words(`MEM_WORDS)
  ) i_busMemory (
    .clk     (clk     ),
    .arstN   (arstN   ),
    .memValid(memValid),
    .memReq  (memReq  ),
    .memReady(memReady),
    .memRdata(memRdata)
  );

endmodule

`default_nettype wire

//--- hdl/busMemory.sv
// Word-addressed single-port bus RAM with fixed wait states and byte-masked writes
`timescale 1ns/1ns
`include "memSys_defines.svh"
`default_nettype none

module busMemory #(
  parameter int words = `MEM_WORDS
) (
  input  logic              clk,
  input  logic              arstN,
  input  logic              memValid,
  input  memSysPkg::busReqT memReq,
  output logic              memReady,
  output memSysPkg::wordT   memRdata
);
  import memSysPkg::*;

  localparam int idxW = $clog2(words);
  localparam int cntW = $clog2(`MEM_WAIT + 2);

  wordT            mem [words];
  logic [cntW-1:0] waitCnt;
  logic [idxW-1:0] wordIdx;
  logic            complete;

  // Upper address bits wrap around the array
  assign wordIdx  = memReq.addr[2 +: idxW];
  assign complete = memValid && !memReady && (waitCnt == cntW'(`MEM_WAIT));

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      memReady <= 1'b0;
      waitCnt  <= '0;
    end
    else if (memReady)
    begin
      // One-cycle ready pulse, then back to waiting
      memReady <= 1'b0;
      waitCnt  <= '0;
    end
    else if (complete)
    begin
      memReady <= 1'b1;
      waitCnt  <= '0;
    end
    else if (memValid)
    begin
      waitCnt <= waitCnt + cntW'(1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (complete)
    begin
      memRdata <= mem[wordIdx];
      if (memReq.write)
      begin
        for (int b = 0; b < 4; b++)
        begin
          if (memReq.byteMask[b])
            mem[wordIdx][8*b +: 8] <= memReq.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/busArbiter.sv
// Shared bus arbiter with data-side priority and per-transfer grant lock
`timescale 1ns/1ns
`default_nettype none

module busArbiter (
  input  logic              clk,
  input  logic              arstN,
  input  logic              iValid,
  input  memSysPkg::busReqT iReq,
  output logic              iReady,
  input  logic              dValid,
  input  memSysPkg::busReqT dReq,
  output logic              dReady,
  output logic              memValid,
  output memSysPkg::busReqT memReq,
  input  logic              memReady
);

  typedef enum logic [1:0] {
    grantNone,
    grantI,
    grantD
  } grantE;

  grantE grantQ;
  grantE sel;

  // Locked owner if a transfer is running, else pick a new one this cycle
  always_comb
  begin
    sel = grantQ;
    if (grantQ == grantNone)
    begin
      if (dValid)
        sel = grantD;
      else if (iValid)
        sel = grantI;
    end
  end

  assign memValid = (sel != grantNone);
  assign memReq   = (sel == grantI) ? iReq : dReq;
  assign iReady   = memReady && (sel == grantI);
  assign dReady   = memReady && (sel == grantD);

  // Grant is held from the first cycle of a transfer until memReady
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      grantQ <= grantNone;
    end
    else if (memReady)
    begin
      grantQ <= grantNone;
    end
    else
    begin
      grantQ <= sel;
    end
  end

endmodule

`default_nettype wire

//--- hdl/dataCache.sv
// Direct-mapped write-through data cache with byte-masked writes and read line fill
`timescale 1ns/1ns
`include "memSys_defines.svh"
`default_nettype none

module dataCache #(
  parameter int lineWords = `LINE_WORDS,
  parameter int lines     = `D_LINES
) (
  input  logic               clk,
  input  logic               arstN,
  input  logic               enable,
  input  logic               invalidate,
  input  logic               dataValid,
  input  memSysPkg::dataReqT dataReq,
  output logic               dataReady,
  output logic               rdValid,
  output memSysPkg::wordT    rdData,
  output logic               busValid,
  output memSysPkg::busReqT  busReq,
  input  logic               busReady,
  input  memSysPkg::wordT    busRdata
);
  import memSysPkg::*;

  localparam int offW = $clog2(lineWords);
  localparam int idxW = $clog2(lines);
  localparam int tagW = 32 - 2 - offW - idxW;

  logic [tagW-1:0]  tagArr [lines];
  wordT             dataArr [lines*lineWords];
  logic [lines-1:0] validBits;

  fillStateE       state;
  dataReqT         reqQ;
  logic [offW-1:0] fillCnt;

  logic [tagW-1:0] inTag;
  logic [idxW-1:0] inIdx;
  logic [offW-1:0] inOff;
  logic [idxW-1:0] reqIdx;
  logic [offW-1:0] reqOff;
  logic            hit;
  logic            accept;
  logic            beat;
  logic            lastBeat;

  assign inTag  = dataReq.addr[31 -: tagW];
  assign inIdx  = dataReq.addr[2+offW +: idxW];
  assign inOff  = dataReq.addr[2 +: offW];
  assign reqIdx = reqQ.addr[2+offW +: idxW];
  assign reqOff = reqQ.addr[2 +: offW];

  assign hit       = validBits[inIdx] && (tagArr[inIdx] == inTag);
  assign dataReady = (state == idle) && !invalidate;
  assign accept    = dataValid && dataReady;
  assign busValid  = (state == fill) || (state == single) || (state == writeThru);
  assign beat      = busValid && busReady;
  assign lastBeat  = (fillCnt + offW'(1)) == reqOff;

  // Writes and single reads go out as captured, fills walk the line
  always_comb
  begin
    busReq = reqQ;
    if (state == fill)
    begin
      busReq.addr[2 +: offW] = fillCnt;
    end
  end

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      state     <= idle;
      validBits <= '0;
      rdValid   <= 1'b0;
      fillCnt   <= '0;
    end
    else
    begin
      rdValid <= 1'b0;
      case (state)
        idle:
        begin
          if (accept)
          begin
            if (dataReq.write)
              state <= writeThru;
            else if (!enable)
              state <= single;
            else if (hit)
              rdValid <= 1'b1;
            else
            begin
              state            <= fill;
              fillCnt          <= inOff;
              validBits[inIdx] <= 1'b0;
            end
          end
        end
        fill:
        begin
          if (beat)
          begin
            if (fillCnt == reqOff)
              rdValid <= 1'b1;
            fillCnt <= fillCnt + offW'(1);
            if (lastBeat)
              state <= done;
          end
        end
        single:
        begin
          if (beat)
          begin
            rdValid <= 1'b1;
            state   <= idle;
          end
        end
        writeThru:
        begin
          // Write is finished once memory takes it
          if (beat)
            state <= idle;
        end
        done:
        begin
          validBits[reqIdx] <= 1'b1;
          state             <= idle;
        end
        default:
          state <= idle;
      endcase
      if (invalidate)
        validBits <= '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      reqQ   <= dataReq;
      rdData <= dataArr[{inIdx, inOff}];
      // Read miss claims the line, write miss leaves the cache alone
      if (!dataReq.write && enable && !hit)
        tagArr[inIdx] <= inTag;
      if (dataReq.write && enable && hit)
      begin
        for (int b = 0; b < 4; b++)
        begin
          if (dataReq.byteMask[b])
            dataArr[{inIdx, inOff}][8*b +: 8] <= dataReq.wdata[8*b +: 8];
        end
      end
    end
    if (beat)
    begin
      if (state == fill)
        dataArr[{reqIdx, fillCnt}] <= busRdata;
      if ((state == single) || ((state == fill) && (fillCnt == reqOff)))
        rdData <= busRdata;
    end
  end

endmodule

`default_nettype wire

//--- hdl/instrCache.sv
// Direct-mapped read-only instruction cache with critical-word-first line fill
`timescale 1ns/1ns
`include "memSys_defines.svh"
`default_nettype none

module instrCache #(
  parameter int lineWords = `LINE_WORDS,
  parameter int lines     = `I_LINES
) (
  input  logic              clk,
  input  logic              arstN,
  input  logic              enable,
  input  logic              invalidate,
  input  logic              fetchValid,
  input  memSysPkg::addrT   fetchAddr,
  output logic              fetchReady,
  output logic              instrValid,
  output memSysPkg::wordT   instr,
  output logic              busValid,
  output memSysPkg::busReqT busReq,
  input  logic              busReady,
  input  memSysPkg::wordT   busRdata
);
  import memSysPkg::*;

  localparam int offW = $clog2(lineWords);
  localparam int idxW = $clog2(lines);
  localparam int tagW = 32 - 2 - offW - idxW;

  logic [tagW-1:0]  tagArr [lines];
  wordT             dataArr [lines*lineWords];
  logic [lines-1:0] validBits;

  fillStateE       state;
  addrT            reqAddr;
  logic [offW-1:0] fillCnt;

  logic [tagW-1:0] fetchTag;
  logic [idxW-1:0] fetchIdx;
  logic [offW-1:0] fetchOff;
  logic [idxW-1:0] reqIdx;
  logic [offW-1:0] reqOff;
  logic            hit;
  logic            accept;
  logic            beat;
  logic            lastBeat;

  // Address split: tag | index | word in line | byte
  assign fetchTag = fetchAddr[31 -: tagW];
  assign fetchIdx = fetchAddr[2+offW +: idxW];
  assign fetchOff = fetchAddr[2 +: offW];
  assign reqIdx   = reqAddr[2+offW +: idxW];
  assign reqOff   = reqAddr[2 +: offW];

  assign hit        = validBits[fetchIdx] && (tagArr[fetchIdx] == fetchTag);
  assign fetchReady = (state == idle) && !invalidate;
  assign accept     = fetchValid && fetchReady;
  assign busValid   = (state == fill) || (state == single);
  assign beat       = busValid && busReady;

  // Fill starts at the requested word and wraps, so the last beat lands just before it
  assign lastBeat = (fillCnt + offW'(1)) == reqOff;

  always_comb
  begin
    busReq          = '0;
    busReq.addr     = reqAddr;
    busReq.byteMask = '1;
    if (state == fill)
    begin
      busReq.addr[2 +: offW] = fillCnt;
    end
  end

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      state      <= idle;
      validBits  <= '0;
      instrValid <= 1'b0;
      fillCnt    <= '0;
    end
    else
    begin
      instrValid <= 1'b0;
      case (state)
        idle:
        begin
          if (accept)
          begin
            if (!enable)
              state <= single;
            else if (hit)
              instrValid <= 1'b1;
            else
            begin
              state               <= fill;
              fillCnt             <= fetchOff;
              validBits[fetchIdx] <= 1'b0;
            end
          end
        end
        fill:
        begin
          if (beat)
          begin
            // Critical word goes straight to the core
            if (fillCnt == reqOff)
              instrValid <= 1'b1;
            fillCnt <= fillCnt + offW'(1);
            if (lastBeat)
              state <= done;
          end
        end
        single:
        begin
          if (beat)
          begin
            instrValid <= 1'b1;
            state      <= idle;
          end
        end
        done:
        begin
          validBits[reqIdx] <= 1'b1;
          state             <= idle;
        end
        default:
          state <= idle;
      endcase
      // Flush wins over a line completing in the same cycle
      if (invalidate)
        validBits <= '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      reqAddr <= fetchAddr;
      instr   <= dataArr[{fetchIdx, fetchOff}];
      if (enable && !hit)
        tagArr[fetchIdx] <= fetchTag;
    end
    if (beat)
    begin
      if (state == fill)
        dataArr[{reqIdx, fillCnt}] <= busRdata;
      if ((state == single) || (fillCnt == reqOff))
        instr <= busRdata;
    end
  end

endmodule

`default_nettype wire

//--- hdl/memSysPkg.sv
// Width typedefs, data and bus request structs, cache controller state enum
`default_nettype none

package memSysPkg;

  // Byte address, bits 1:0 ignored since every access is word aligned
  typedef logic [31:0] addrT;
  typedef logic [31:0] wordT;

  // Bit n enables byte lane n
  typedef logic [3:0] byteMaskT;

  // Request from the core data port
  typedef struct packed {
    addrT     addr;
    logic     write;
    wordT     wdata;
    byteMaskT byteMask;
  } dataReqT;

  // One transfer on the shared bus
  typedef struct packed {
    addrT     addr;
    logic     write;
    wordT     wdata;
    byteMaskT byteMask;
  } busReqT;

  // Cache controller states, shared by both caches
  typedef enum logic [2:0] {
    idle,
    fill,
    single,
    writeThru,
    done
  } fillStateE;

endpackage

`default_nettype wire

//--- hdl/memSys_defines.svh
// Cache line geometry, cache line counts, memory depth and memory wait states
`ifndef MEMSYS_DEFINES_SVH
`define MEMSYS_DEFINES_SVH

`default_nettype none

// Words per cache line
`define LINE_WORDS 4

// Lines in each cache
`define I_LINES 64
`define D_LINES 64

// Memory depth in 32-bit words (16 KiB)
`define MEM_WORDS 4096

// Wait cycles before the memory completes a transfer
`define MEM_WAIT 2

`default_nettype wire

`endif
